// ==== cart_pkg.sv ====
package cart_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [23:0] addr_t;
  typedef logic [2:0]  mapper_t;
  typedef logic [15:0] byte_cnt_t;   // 1 = command byte
  typedef logic [31:0] freq_t;

  // upper nibble of the command byte
  typedef enum logic [3:0] {
    grp_addr      = 4'h0,
    grp_rom_mask  = 4'h1,
    grp_sram_mask = 4'h2,
    grp_mapper    = 4'h3,
    grp_read      = 4'h8,
    grp_write     = 4'h9,
    grp_misc      = 4'hF
  } cmd_grp_t;

  // full-byte commands in the misc group
  localparam byte_t cmd_sig  = 8'hF0;
  localparam byte_t cmd_freq = 8'hFE;
  localparam byte_t cmd_echo = 8'hFF;

  localparam byte_t   sig_value  = 8'hA5;
  localparam mapper_t mapper_rst = 3'd1;

endpackage

// ==== mcu_byte_if.sv ====
interface mcu_byte_if;
  import cart_pkg::*;

  logic      cmd_ready;
  logic      param_ready;
  byte_t     rx_byte;
  byte_cnt_t byte_cnt;
  byte_t     tx_byte;
  logic      tx_load;

  modport slave_side (
    output cmd_ready, param_ready, rx_byte, byte_cnt,
    input  tx_byte, tx_load
  );

  modport cmd_side (
    input  cmd_ready, param_ready, rx_byte, byte_cnt,
    output tx_byte, tx_load
  );

endinterface

// ==== mem_req_if.sv ====
interface mem_req_if;
  import cart_pkg::*;

  // request side
  logic  req_valid;
  logic  req_write;
  addr_t req_addr;
  byte_t req_wdata;

  // return side
  logic  credit_ret;   // one per retired request
  logic  rd_valid;
  byte_t rd_data;

  modport issuer (
    output req_valid, req_write, req_addr, req_wdata,
    input  credit_ret, rd_valid, rd_data
  );

  modport target (
    input  req_valid, req_write, req_addr, req_wdata,
    output credit_ret, rd_valid, rd_data
  );

endinterface

// ==== spi_slave.sv ====
module spi_slave (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           spi_sck,
  input  logic           spi_mosi,
  input  logic           spi_cs_n,
  output logic           spi_miso,
  mcu_byte_if.slave_side bus
);
  import cart_pkg::*;

  typedef enum logic {st_idle, st_shifting} state_t;

  state_t     state;
  logic [2:0] pin_s1;     // {cs_n, mosi, sck}
  logic [2:0] pin_s2;
  logic       sck_q;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;
  byte_t      shift_in;
  byte_t      tx_hold;
  byte_t      tx_shift;

  assign sck_rise = pin_s2[0] & ~sck_q;
  assign sck_fall = ~pin_s2[0] & sck_q;
  assign spi_miso = tx_shift[7];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pin_s1          <= 3'b100;
      pin_s2          <= 3'b100;
      sck_q           <= 1'b0;
      state           <= st_idle;
      bit_cnt         <= '0;
      tx_shift        <= '0;
      bus.byte_cnt    <= '0;
      bus.cmd_ready   <= 1'b0;
      bus.param_ready <= 1'b0;
    end else begin
      pin_s1          <= {spi_cs_n, spi_mosi, spi_sck};
      pin_s2          <= pin_s1;
      sck_q           <= pin_s2[0];
      bus.cmd_ready   <= 1'b0;
      bus.param_ready <= 1'b0;
      case (state)
        st_idle: if (!pin_s2[2]) begin
          state        <= st_shifting;   // new transaction
          bit_cnt      <= '0;
          bus.byte_cnt <= '0;
          tx_shift     <= '0;
        end
        st_shifting: begin
          if (pin_s2[2]) begin
            state <= st_idle;
          end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              bus.byte_cnt    <= bus.byte_cnt + 16'd1;
              bus.cmd_ready   <= (bus.byte_cnt == '0);
              bus.param_ready <= (bus.byte_cnt != '0);
            end
          end else if (sck_fall) begin
            // last falling edge of a byte presents the next reply MSB
            tx_shift <= (bit_cnt == 3'd0) ? tx_hold : {tx_shift[6:0], 1'b0};
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bus.tx_load) tx_hold <= bus.tx_byte;
    if (state == st_shifting && sck_rise) begin
      shift_in <= {shift_in[6:0], pin_s2[1]};   // msb first
      if (bit_cnt == 3'd7) bus.rx_byte <= {shift_in[6:0], pin_s2[1]};
    end
  end

  // chip select only rises between whole bytes
  a_whole_bytes: assert property (@(posedge clk) disable iff (!rst_n)
    (state == st_shifting && pin_s2[2]) |-> bit_cnt == 3'd0);

endmodule

// ==== clk_meter.sv ====
module clk_meter #(
  parameter int WINDOW = 1024
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sys_clk_ext,
  output cart_pkg::freq_t freq
);
  import cart_pkg::*;

  localparam int WW = (WINDOW > 1) ? $clog2(WINDOW) : 1;

  logic [2:0]    ext_sync;   // two sync flops plus edge history
  logic          ext_rise;
  logic [WW-1:0] win_cnt;
  freq_t         edge_cnt;

  assign ext_rise = ext_sync[1] & ~ext_sync[2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ext_sync <= '0;
      win_cnt  <= '0;
      edge_cnt <= '0;
      freq     <= '0;
    end else begin
      ext_sync <= {ext_sync[1:0], sys_clk_ext};
      if (win_cnt == WW'(WINDOW - 1)) begin
        win_cnt  <= '0;
        freq     <= edge_cnt + freq_t'(ext_rise);   // window closed
        edge_cnt <= '0;
      end else begin
        win_cnt  <= win_cnt + 1'b1;
        edge_cnt <= edge_cnt + freq_t'(ext_rise);
      end
    end
  end

endmodule

// ==== mcu_cmd.sv ====
module mcu_cmd #(
  parameter int CREDITS = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  mcu_byte_if.cmd_side      bus,
  mem_req_if.issuer         mem,
  input  cart_pkg::freq_t   freq,
  output cart_pkg::mapper_t mapper,
  output cart_pkg::addr_t   rom_mask,
  output cart_pkg::addr_t   sram_mask,
  output cart_pkg::addr_t   mem_addr
);
  import cart_pkg::*;

  localparam int CW = $clog2(CREDITS + 1);

  byte_t         cmd;
  byte_t         cur_cmd;
  cmd_grp_t      cur_grp;
  byte_t         reply;
  freq_t         freq_buf;
  logic [CW-1:0] credits;
  logic          pend_valid;
  logic          pend_write;
  addr_t         pend_addr;
  byte_t         pend_wdata;
  logic          stream;
  logic          issue;
  logic          tx_go;

  // place a parameter byte, msb first over byte counts 2..4
  function automatic addr_t put_byte(addr_t v, byte_cnt_t n, byte_t b);
    addr_t r;
    r = v;
    case (n)
      16'd2:   r[23:16] = b;
      16'd3:   r[15:8]  = b;
      16'd4:   r[7:0]   = b;
      default: r = v;
    endcase
    return r;
  endfunction

  assign cur_cmd = bus.cmd_ready ? bus.rx_byte : cmd;
  assign cur_grp = cmd_grp_t'(cur_cmd[7:4]);
  assign stream  = bus.param_ready && (cur_grp == grp_read || cur_grp == grp_write);
  assign issue   = pend_valid && (credits != '0);
  assign tx_go   = mem.rd_valid || bus.cmd_ready || (bus.param_ready && cur_grp != grp_read);

  always_comb begin
    reply = '0;
    if (cur_cmd == cmd_sig) begin
      reply = sig_value;
    end else if (cur_cmd == cmd_echo && bus.param_ready) begin
      reply = bus.rx_byte;
    end else if (cur_cmd == cmd_freq) begin
      case (bus.byte_cnt)
        16'd1:   reply = freq[31:24];   // buffer not latched yet
        16'd2:   reply = freq_buf[23:16];
        16'd3:   reply = freq_buf[15:8];
        16'd4:   reply = freq_buf[7:0];
        default: reply = '0;
      endcase
    end
  end

  ////////////////////
  // command registers and request issue
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd           <= '0;
      mapper        <= mapper_rst;
      rom_mask      <= '0;
      sram_mask     <= '0;
      mem_addr      <= '0;
      credits       <= CW'(CREDITS);
      pend_valid    <= 1'b0;
      mem.req_valid <= 1'b0;
      bus.tx_load   <= 1'b0;
    end else begin
      bus.tx_load   <= tx_go;
      mem.req_valid <= issue;
      credits       <= credits - CW'(issue) + CW'(mem.credit_ret);
      if (issue) pend_valid <= 1'b0;
      if (stream) pend_valid <= 1'b1;
      if (bus.cmd_ready) begin
        cmd <= bus.rx_byte;
        if (cur_grp == grp_mapper) mapper <= bus.rx_byte[2:0];
      end else if (bus.param_ready) begin
        case (cur_grp)
          grp_addr:      mem_addr  <= (bus.byte_cnt == 16'd2) ? {bus.rx_byte, 16'h0000}
                                      : put_byte(mem_addr, bus.byte_cnt, bus.rx_byte);
          grp_rom_mask:  rom_mask  <= put_byte(rom_mask, bus.byte_cnt, bus.rx_byte);
          grp_sram_mask: sram_mask <= put_byte(sram_mask, bus.byte_cnt, bus.rx_byte);
          grp_read,
          grp_write:     if (cur_cmd[3]) mem_addr <= mem_addr + 24'd1;   // auto-increment
          default:       ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.cmd_ready && bus.rx_byte == cmd_freq) freq_buf <= freq;
    if (stream) begin
      pend_write <= (cur_grp == grp_write);
      pend_addr  <= mem_addr;
      pend_wdata <= bus.rx_byte;
    end
    if (issue) begin
      mem.req_write <= pend_write;
      mem.req_addr  <= pend_addr;
      mem.req_wdata <= pend_wdata;
    end
    if (tx_go) bus.tx_byte <= mem.rd_valid ? mem.rd_data : reply;   // read data wins
  end

  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CW'(CREDITS));
  // a waiting request is never overwritten by the next one
  a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
    stream |-> (!pend_valid || issue));

endmodule

// ==== mem_port.sv ====
module mem_port #(
  parameter int CREDITS = 4,
  parameter int MEM_AW  = 10
) (
  input  logic      clk,
  input  logic      rst_n,
  mem_req_if.target mem
);
  import cart_pkg::*;

  localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int CW = $clog2(CREDITS + 1);

  logic              q_write [CREDITS];
  logic [MEM_AW-1:0] q_addr  [CREDITS];
  byte_t             q_data  [CREDITS];
  byte_t             ram     [2**MEM_AW];
  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     rd_ptr;
  logic [CW-1:0]     count;
  logic              busy;      // head popped, access next cycle
  logic              pop;
  logic              x_write;
  logic [MEM_AW-1:0] x_addr;
  byte_t             x_data;

  function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] p);
    return (p == PW'(CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop = !busy && (count != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      busy           <= 1'b0;
      mem.credit_ret <= 1'b0;
      mem.rd_valid   <= 1'b0;
    end else begin
      if (mem.req_valid) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count          <= count + CW'(mem.req_valid) - CW'(pop);
      busy           <= pop;
      mem.credit_ret <= busy;              // retire
      mem.rd_valid   <= busy && !x_write;
    end
  end

  always_ff @(posedge clk) begin
    if (mem.req_valid) begin
      q_write[wr_ptr] <= mem.req_write;
      q_addr[wr_ptr]  <= mem.req_addr[MEM_AW-1:0];   // wraps on low bits
      q_data[wr_ptr]  <= mem.req_wdata;
    end
    if (pop) begin
      x_write <= q_write[rd_ptr];
      x_addr  <= q_addr[rd_ptr];
      x_data  <= q_data[rd_ptr];
    end
    if (busy && x_write) ram[x_addr] <= x_data;
    if (busy && !x_write) mem.rd_data <= ram[x_addr];
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    mem.req_valid |-> count < CW'(CREDITS));

endmodule

// ==== cart_ctrl_top.sv ====
module cart_ctrl_top #(
  parameter int MEM_AW  = 10,
  parameter int CREDITS = 4,
  parameter int WINDOW  = 1024
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              spi_sck,
  input  logic              spi_mosi,
  input  logic              spi_cs_n,
  input  logic              sys_clk_ext,
  output logic              spi_miso,
  output cart_pkg::mapper_t mapper,
  output cart_pkg::addr_t   rom_mask,
  output cart_pkg::addr_t   sram_mask,
  output cart_pkg::addr_t   mem_addr
);
  import cart_pkg::*;

  freq_t freq;

  mcu_byte_if byte_bus ();
  mem_req_if  mem_bus ();

  spi_slave u_spi (
    .clk, .rst_n, .spi_sck, .spi_mosi, .spi_cs_n, .spi_miso,
    .bus (byte_bus.slave_side)
  );

  clk_meter #(.WINDOW(WINDOW)) u_meter (
    .clk, .rst_n, .sys_clk_ext,
    .freq (freq)
  );

  mcu_cmd #(.CREDITS(CREDITS)) u_cmd (
    .clk, .rst_n,
    .bus  (byte_bus.cmd_side),
    .mem  (mem_bus.issuer),
    .freq (freq),
    .mapper, .rom_mask, .sram_mask, .mem_addr
  );

  mem_port #(.CREDITS(CREDITS), .MEM_AW(MEM_AW)) u_mem (
    .clk, .rst_n,
    .mem (mem_bus.target)
  );

endmodule

// ==== tb_cart_ctrl.sv ====
module tb_cart_ctrl;
  import cart_pkg::*;

  localparam int HALF   = 16;     // sck half period in clk cycles
  localparam int WINDOW = 1024;

  logic    clk;
  logic    rst_n;
  logic    spi_sck;
  logic    spi_mosi;
  logic    spi_cs_n;
  logic    sys_clk_ext;
  logic    spi_miso;
  mapper_t mapper;
  addr_t   rom_mask;
  addr_t   sram_mask;
  addr_t   mem_addr;

  byte_t       mosi_buf [32];   // index 0 is the command byte
  byte_t       miso_buf [32];
  byte_t       data     [16];
  logic [31:0] rng;

  cart_ctrl_top #(.WINDOW(WINDOW)) DUT (
    .clk, .rst_n, .spi_sck, .spi_mosi, .spi_cs_n, .sys_clk_ext,
    .spi_miso, .mapper, .rom_mask, .sram_mask, .mem_addr
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // external system clock, period 8 clk
  initial begin
    forever begin
      repeat (4) @(posedge clk);
      sys_clk_ext <= ~sys_clk_ext;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic fail(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) fail($sformatf("Fail %s: got 0x%02h exp 0x%02h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) fail($sformatf("Fail %s: got 0x%06h exp 0x%06h", name, got, exp));
  endtask

  task automatic check_mapper(input string name, input mapper_t got, input mapper_t exp);
    if (got !== exp) fail($sformatf("Fail %s: got 0x%01h exp 0x%01h", name, got, exp));
  endtask

  task automatic check_freq(input string name, input freq_t got, input freq_t exp);
    if ($isunknown(got) || got > exp + 1 || got + 1 < exp)   // one edge of slack
      fail($sformatf("Fail %s: got 0x%08h exp 0x%08h", name, got, exp));
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  ////////////////////
  // spi mode 0 master, miso sampled just before each rising sck
  task automatic spi_xfer(input int n);
    byte_t rx;
    @(posedge clk);
    spi_cs_n <= 1'b0;
    wait_clks(HALF);
    for (int i = 0; i < n; i++) begin
      for (int b = 7; b >= 0; b--) begin
        spi_mosi <= mosi_buf[i][b];
        wait_clks(HALF);
        rx[b] = spi_miso;
        spi_sck <= 1'b1;
        wait_clks(HALF);
        spi_sck <= 1'b0;
      end
      miso_buf[i] = rx;
    end
    wait_clks(HALF);
    spi_cs_n <= 1'b1;
    wait_clks(HALF);
  endtask

  task automatic send_cmd3(input byte_t cmd, input addr_t val);
    mosi_buf[0] = cmd;
    mosi_buf[1] = val[23:16];
    mosi_buf[2] = val[15:8];
    mosi_buf[3] = val[7:0];
    spi_xfer(4);
  endtask

  ////////////////////
  task automatic mapper_select();
    check_mapper("mapper", mapper, 3'd1);
    check_addr("rom_mask", rom_mask, 24'h0);
    check_addr("sram_mask", sram_mask, 24'h0);
    check_addr("mem_addr", mem_addr, 24'h0);
    mosi_buf[0] = 8'h35;
    spi_xfer(1);
    check_mapper("mapper", mapper, 3'd5);
  endtask

  task automatic mask_load();
    send_cmd3(8'h10, 24'hC3_5A_0F);
    check_addr("rom_mask", rom_mask, 24'hC3_5A_0F);
    send_cmd3(8'h20, 24'h01_E2_7D);
    check_addr("sram_mask", sram_mask, 24'h01_E2_7D);
    send_cmd3(8'h00, 24'h9B_46_21);
    check_addr("mem_addr", mem_addr, 24'h9B_46_21);
  endtask

  task automatic stream_rw();
    addr_t base;
    base = 24'h12_0340;   // above the ram size, wraps
    send_cmd3(8'h00, base);
    mosi_buf[0] = 8'h98;
    for (int i = 0; i < 16; i++) begin
      rng = xorshift32(rng);
      data[i] = rng[7:0];
      mosi_buf[i + 1] = data[i];
    end
    spi_xfer(17);
    check_addr("mem_addr", mem_addr, base + 24'd16);
    send_cmd3(8'h00, base);
    mosi_buf[0] = 8'h88;
    for (int i = 1; i < 18; i++) mosi_buf[i] = 8'h00;
    spi_xfer(18);
    for (int i = 0; i < 16; i++)   // read data lags its request by one byte
      check_byte($sformatf("spi_miso byte %0d", i + 3), miso_buf[i + 2], data[i]);
    check_addr("mem_addr", mem_addr, base + 24'd17);
  endtask

  task automatic sig_and_echo();
    mosi_buf[0] = 8'hF0;
    mosi_buf[1] = 8'h00;
    spi_xfer(2);
    check_byte("spi_miso signature", miso_buf[1], 8'hA5);
    mosi_buf[0] = 8'hFF;
    for (int i = 1; i < 6; i++) begin
      rng = xorshift32(rng);
      mosi_buf[i] = rng[7:0];
    end
    spi_xfer(6);
    for (int k = 1; k < 5; k++)
      check_byte($sformatf("spi_miso echo byte %0d", k + 2), miso_buf[k + 1], mosi_buf[k]);
  endtask

  task automatic freq_readout();
    freq_t f;
    wait_clks(2 * WINDOW + 16);   // two full meter windows
    mosi_buf[0] = 8'hFE;
    for (int i = 1; i < 5; i++) mosi_buf[i] = 8'h00;
    spi_xfer(5);
    f = {miso_buf[1], miso_buf[2], miso_buf[3], miso_buf[4]};
    check_freq("freq", f, freq_t'(WINDOW / 8));
  endtask

  initial begin
    rst_n       = 1'b0;
    spi_sck     = 1'b0;
    spi_mosi    = 1'b0;
    spi_cs_n    = 1'b1;
    sys_clk_ext = 1'b0;
    rng         = 32'he52b_48f9;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    wait_clks(4);
    mapper_select();
    mask_load();
    stream_rw();
    sig_and_echo();
    freq_readout();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== tb.f ====
cart_pkg.sv
mcu_byte_if.sv
mem_req_if.sv
spi_slave.sv
clk_meter.sv
mcu_cmd.sv
mem_port.sv
cart_ctrl_top.sv
tb_cart_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cart_ctrl
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
